// File: files.f
verilog/fm_pkg.sv
verilog/slot_if.sv
verilog/operator_sequencer.sv
verilog/fm_waveform_tables.sv
verilog/phase_generator.sv
verilog/operator_output_buffer.sv
verilog/channel_mixer.sv
verilog/fm_operator_core.sv
verification/clock_gen.sv
verification/fm_properties.sv
verification/fm_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the FM operator core testbench with Verilator, runs it and
# reports success only when the pass message shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module fm_tb -Mdir obj_dir \
    && ./obj_dir/Vfm_tb +verilator+error+limit+1000 \
        | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

// File: verification/fm_tb.sv
/*
 * Testbench top for the FM operator core.
 * Each test writes operator records and runs eight frames while the bound
 * assertions check the samples, then one result line is printed.
 */
`timescale 1ns/10ps
`default_nettype none

module fm_tb import fm_pkg::*; ();

    localparam int FRAMES = 8;
    localparam int FRAME_TIMEOUT = 40;
    localparam int RESET_TIMEOUT = 10;

    logic    clk;
    logic    rst_n;
    logic    is_new;
    logic    sample_en;
    logic    reg_we;
    op_idx_t reg_op;
    phase_t  reg_phase_inc;
    ws_t     reg_ws;
    env_t    reg_env;
    logic    reg_key_on;
    sample_t sample;
    logic    sample_valid;

    int seed;
    int timeouts;
    int tests_run;
    int tests_failed;
    int assert_base;
    int timeout_base;

    clock_gen clocks (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fm_operator_core #(.num_ops(NUM_OPS)) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .is_new        (is_new),
        .sample_en     (sample_en),
        .reg_we        (reg_we),
        .reg_op        (reg_op),
        .reg_phase_inc (reg_phase_inc),
        .reg_ws        (reg_ws),
        .reg_env       (reg_env),
        .reg_key_on    (reg_key_on),
        .sample        (sample),
        .sample_valid  (sample_valid)
    );

    bind fm_operator_core fm_properties props (
        .clk           (clk),
        .rst_n         (rst_n),
        .is_new        (is_new),
        .sample_en     (sample_en),
        .reg_we        (reg_we),
        .reg_op        (reg_op),
        .reg_phase_inc (reg_phase_inc),
        .reg_ws        (reg_ws),
        .reg_env       (reg_env),
        .reg_key_on    (reg_key_on),
        .sample        (sample),
        .sample_valid  (sample_valid)
    );

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        while (!rst_n && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!rst_n) begin
            $display("reset was not released within %0d clocks", RESET_TIMEOUT);
            timeouts++;
        end
    endtask

    // One complete operator record per write.
    task automatic write_op(input op_idx_t op, input phase_t inc, input ws_t ws,
                            input env_t env, input logic key_on);
        @(posedge clk);
        reg_we <= 1'b1;
        reg_op <= op;
        reg_phase_inc <= inc;
        reg_ws <= ws;
        reg_env <= env;
        reg_key_on <= key_on;
        @(posedge clk);
        reg_we <= 1'b0;
    endtask

    // Modulators take waveform 0, carriers the given one, all with random increments.
    task automatic configure_channels(input ws_t carrier_ws, input env_t mod_env,
                                      input env_t carrier_env);
        for (int i = 0; i < NUM_OPS; i++) begin
            if (i % 2 == 1) begin
                write_op(op_idx_t'(i), phase_t'($random(seed)), carrier_ws, carrier_env, 1'b0);
            end else begin
                write_op(op_idx_t'(i), phase_t'($random(seed)), 3'd0, mod_env, 1'b0);
            end
        end
    endtask

    // Strobe, wait for the sample, then pad so strobes are 20 clocks apart.
    task automatic run_frame(input logic extra_strobe);
        int waited;
        @(posedge clk);
        sample_en <= 1'b1;
        @(posedge clk);
        sample_en <= 1'b0;
        // A strobe inside a running frame must be ignored.
        if (extra_strobe) begin
            repeat (5) @(posedge clk);
            sample_en <= 1'b1;
            @(posedge clk);
            sample_en <= 1'b0;
        end
        waited = 0;
        @(negedge clk);
        while (!sample_valid && waited < FRAME_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!sample_valid) begin
            $display("no sample_valid within %0d clocks of sample_en", FRAME_TIMEOUT);
            timeouts++;
        end
        repeat (3) @(posedge clk);
    endtask

    task automatic run_frames(input logic extra_strobe);
        for (int f = 0; f < FRAMES; f++) begin
            run_frame(extra_strobe);
        end
    endtask

    task automatic start_test();
        assert_base = uut.props.fail_count;
        timeout_base = timeouts;
    endtask

    task automatic finish_test(input string name);
        int failures;
        failures = (uut.props.fail_count - assert_base) + (timeouts - timeout_base);
        tests_run++;
        if (failures == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, failures);
        end
    endtask

    initial begin
        seed = 32'hbd492510;
        timeouts = 0;
        tests_run = 0;
        tests_failed = 0;
        is_new = 1'b1;
        sample_en = 1'b0;
        reg_we = 1'b0;
        reg_op = '0;
        reg_phase_inc = '0;
        reg_ws = '0;
        reg_env = '0;
        reg_key_on = 1'b0;

        // The reset checks belong to the first test.
        start_test();
        wait_for_reset();
        run_frames(1'b1);
        finish_test("reset_and_strobe");

        start_test();
        configure_channels(3'd2, 9'h1ff, 9'h1ff);
        run_frames(1'b0);
        finish_test("muting");

        start_test();
        configure_channels(3'd1, 9'h1ff, 9'h000);
        run_frames(1'b0);
        finish_test("half_sine");

        start_test();
        configure_channels(3'd6, 9'h1ff, 9'h000);
        run_frames(1'b0);
        finish_test("square_opl3");

        // Same records while OPL2 mode masks the waveform to two bits.
        start_test();
        @(posedge clk);
        is_new <= 1'b0;
        run_frames(1'b0);
        finish_test("square_opl2");

        start_test();
        @(posedge clk);
        is_new <= 1'b1;
        for (int i = 0; i < NUM_OPS; i++) begin
            write_op(op_idx_t'(i), '0, 3'd0, 9'h000, 1'b1);
        end
        run_frames(1'b0);
        finish_test("key_on_frozen");

        $display("tests %0d, failed %0d, assertion failures %0d, timeouts %0d",
            tests_run, tests_failed, uut.props.fail_count, timeouts);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/fm_properties.sv
/*
 * Concurrent checks for the FM operator core, bound to its top level.
 * A shadow of the host writes picks the sample range that each frame must meet.
 */
`timescale 1ns/10ps
`default_nettype none

module fm_properties import fm_pkg::*; (
    input wire logic    clk,
    input wire logic    rst_n,
    input wire logic    is_new,
    input wire logic    sample_en,
    input wire logic    reg_we,
    input wire op_idx_t reg_op,
    input wire phase_t  reg_phase_inc,
    input wire ws_t     reg_ws,
    input wire env_t    reg_env,
    input wire logic    reg_key_on,
    input wire sample_t sample,
    input wire logic    sample_valid
);

    // Read by the testbench after each test.
    int fail_count = 0;

    ws_t                ws_sh [NUM_OPS];
    env_t               env_sh [NUM_OPS];
    // Set once the host has written the operator's record.
    logic [NUM_OPS-1:0] known;
    // Phase increment zero and key-on set.
    logic [NUM_OPS-1:0] frozen_op;
    logic [4:0]         busy_cnt;
    logic               accept;
    logic               all_muted;
    logic               mods_muted;
    logic               carriers_loud;
    logic               mute_frame;
    logic               half_frame;
    logic               square_frame;
    logic               abs_frame;
    logic               frozen_frame;
    sample_t            last_sample;
    int                 quiet_frames;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            known <= '0;
        end else if (reg_we) begin
            known[reg_op] <= 1'b1;
            ws_sh[reg_op] <= reg_ws;
            env_sh[reg_op] <= reg_env;
            frozen_op[reg_op] <= (reg_phase_inc == '0) && reg_key_on;
        end
    end

    always_comb begin
        all_muted = &known;
        for (int i = 0; i < NUM_OPS; i++) begin
            if (env_sh[i] != '1) begin
                all_muted = 1'b0;
            end
        end
    end

    // Channels are ops 0 into 1 and ops 2 into 3.
    assign mods_muted = known[0] && known[2] && env_sh[0] == '1 && env_sh[2] == '1;
    assign carriers_loud = known[1] && known[3] && env_sh[1] == '0 && env_sh[3] == '0;
    // A frame is taken only when none is running.
    assign accept = rst_n && sample_en && busy_cnt == 5'd0;

    // Frame settings are captured at the accepted strobe.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt <= '0;
            mute_frame <= 1'b0;
            half_frame <= 1'b0;
            square_frame <= 1'b0;
            abs_frame <= 1'b0;
            frozen_frame <= 1'b0;
        end else if (accept) begin
            busy_cnt <= 5'd15;
            mute_frame <= all_muted;
            half_frame <= mods_muted && carriers_loud && ws_sh[1] == 3'd1 && ws_sh[3] == 3'd1;
            square_frame <= mods_muted && carriers_loud && is_new
                && ws_sh[1] == 3'd6 && ws_sh[3] == 3'd6;
            abs_frame <= mods_muted && carriers_loud && !is_new
                && ws_sh[1] == 3'd6 && ws_sh[3] == 3'd6;
            frozen_frame <= (&known) && (&frozen_op);
        end else if (busy_cnt != 5'd0) begin
            busy_cnt <= busy_cnt - 5'd1;
        end
    end

    // Counts samples since the last host write and stops at two.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            quiet_frames <= 0;
            last_sample <= '0;
        end else begin
            if (reg_we) begin
                quiet_frames <= 0;
            end else if (sample_valid && quiet_frames < 2) begin
                quiet_frames <= quiet_frames + 1;
            end
            if (sample_valid) begin
                last_sample <= sample;
            end
        end
    end

    reset_clears_outputs: assert property (@(posedge clk)
        !rst_n |=> (sample == '0 && !sample_valid))
    else begin
        $error("error sample=%h sample_valid=%h after reset, expected 0000 and 0",
            sample, sample_valid);
        fail_count++;
    end

    // Exactly 16 clocks after each accepted strobe and at no other time.
    strobe_timing: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid == $past(accept, 16))
    else begin
        $error("error sample_valid=%h, expected %h", sample_valid, !sample_valid);
        fail_count++;
    end

    strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
    else begin
        $error("error sample_valid=1 held for more than one cycle");
        fail_count++;
    end

    mute_range: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && mute_frame |-> (sample >= -16'sd2 && sample <= 16'sd2))
    else begin
        $error("error sample=%h, expected fffe to 0002", sample);
        fail_count++;
    end

    half_sine_positive: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && half_frame |-> sample >= 16'sd0)
    else begin
        $error("error sample=%h, expected 0000 to 7fff", sample);
        fail_count++;
    end

    square_levels: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && square_frame
            |-> (sample == 16'sd16382 || sample == -16'sd1 || sample == -16'sd16384))
    else begin
        $error("error sample=%h, expected 3ffe, ffff or c000", sample);
        fail_count++;
    end

    // OPL2 mode turns square into absolute sine.
    opl2_abs_positive: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && abs_frame |-> sample >= 16'sd0)
    else begin
        $error("error sample=%h, expected 0000 to 7fff", sample);
        fail_count++;
    end

    frozen_equal: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && frozen_frame && quiet_frames >= 2 |-> sample == last_sample)
    else begin
        $error("error sample=%h, expected %h", sample, last_sample);
        fail_count++;
    end

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
/*
 * Testbench clock and reset source.
 * Clock period is 4 ns, rst_n is held low for the first two rising edges.
 */
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released on the second rising edge, so two edges see reset.
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog/fm_operator_core.sv
/*
 * Top level of the FM operator engine, two fixed two-operator channels.
 * The host writes operator records, then pulses sample_en once per sample.
 */
`timescale 1ns/10ps
`default_nettype none

module fm_operator_core import fm_pkg::*; #(
    parameter int num_ops = NUM_OPS
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    is_new,
    input  wire logic    sample_en,
    input  wire logic    reg_we,
    input  wire op_idx_t reg_op,
    input  wire phase_t  reg_phase_inc,
    input  wire ws_t     reg_ws,
    input  wire env_t    reg_env,
    input  wire logic    reg_key_on,
    output sample_t      sample,
    output logic         sample_valid
);

    logic    out_valid;
    op_idx_t out_op;
    op_out_t op_out;
    op_out_t modulation;

    slot_if slot_bus ();

    operator_sequencer sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_en     (sample_en),
        .reg_we        (reg_we),
        .reg_op        (reg_op),
        .reg_phase_inc (reg_phase_inc),
        .reg_ws        (reg_ws),
        .reg_env       (reg_env),
        .reg_key_on    (reg_key_on),
        .slot          (slot_bus.producer)
    );

    phase_generator #(.num_ops(num_ops)) phase_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .is_new     (is_new),
        .slot       (slot_bus.consumer),
        .modulation (modulation),
        .out_valid  (out_valid),
        .out_op     (out_op),
        .out        (op_out)
    );

    // Modulation is looked up with the op_num of the slot being issued.
    operator_output_buffer #(.num_ops(num_ops)) out_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_valid  (out_valid),
        .out_op     (out_op),
        .out        (op_out),
        .slot_op    (slot_bus.op_num),
        .modulation (modulation)
    );

    channel_mixer mixer (
        .clk          (clk),
        .rst_n        (rst_n),
        .out_valid    (out_valid),
        .out_op       (out_op),
        .out          (op_out),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

// File: verilog/channel_mixer.sv
/*
 * Sums the carrier outputs of one frame into a saturated signed sample.
 * The last operator's output closes the frame and pulses sample_valid.
 */
`timescale 1ns/10ps
`default_nettype none

module channel_mixer import fm_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    out_valid,
    input  wire op_idx_t out_op,
    input  wire op_out_t out,
    output sample_t      sample,
    output logic         sample_valid
);

    localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_WIDTH - 1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_WIDTH - 1){1'b0}}};

    sample_t                       acc;
    op_out_t                       addend;
    logic signed [SAMPLE_WIDTH:0]  sum;
    sample_t                       sat;
    logic                          last_op;

    // Only carriers reach the mix.
    assign addend = out_op[0] ? out : '0;
    // One guard bit catches overflow.
    assign sum = (SAMPLE_WIDTH + 1)'(acc) + (SAMPLE_WIDTH + 1)'(addend);

    always_comb begin
        if (sum[SAMPLE_WIDTH] != sum[SAMPLE_WIDTH-1]) begin
            sat = sum[SAMPLE_WIDTH] ? SAMPLE_MIN : SAMPLE_MAX;
        end else begin
            sat = sample_t'(sum);
        end
    end

    assign last_op = (out_op == op_idx_t'(NUM_OPS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
            sample <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (out_valid) begin
                if (last_op) begin
                    sample <= sat;
                    sample_valid <= 1'b1;
                    acc <= '0;
                end else begin
                    acc <= sat;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/operator_output_buffer.sv
/*
 * Latest output of every operator, written on out_valid.
 * Supplies the paired modulator output while a carrier slot is issued.
 */
`timescale 1ns/10ps
`default_nettype none

module operator_output_buffer import fm_pkg::*; #(
    parameter int num_ops = NUM_OPS
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    out_valid,
    input  wire op_idx_t out_op,
    input  wire op_out_t out,
    input  wire op_idx_t slot_op,
    output op_out_t      modulation
);

    op_out_t entry [num_ops];
    // Modulator of a channel sits just below its carrier.
    op_idx_t mod_op;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ops; i++) begin
                entry[i] <= '0;
            end
        end else if (out_valid) begin
            entry[out_op] <= out;
        end
    end

    assign mod_op = {slot_op[OP_IDX_WIDTH-1:1], 1'b0};

    // Odd slots are carriers, modulators get no input.
    assign modulation = slot_op[0] ? entry[mod_op] : '0;

endmodule

`default_nettype wire

// File: verilog/phase_generator.sv
/*
 * Phase accumulation and phase-to-amplitude conversion for every operator.
 * Stage 0 updates the accumulator of the issued slot, stage 1 looks up the
 * tables, shapes the waveform and registers out with out_valid.
 */
`timescale 1ns/10ps
`default_nettype none

module phase_generator import fm_pkg::*; #(
    parameter int num_ops = NUM_OPS
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    is_new,
    slot_if.consumer     slot,
    input  wire op_out_t modulation,
    output logic         out_valid,
    output op_idx_t      out_op,
    output op_out_t      out
);

    localparam int GAIN_WIDTH = 13;
    localparam int MSB = PHASE_ACC_WIDTH - 1;
    localparam op_out_t OUT_MAX = {1'b0, {(OP_OUT_WIDTH - 1){1'b1}}};
    localparam op_out_t OUT_MIN = {1'b1, {(OP_OUT_WIDTH - 1){1'b0}}};

    phase_t               phase_acc [num_ops];
    phase_t               final_phase [num_ops];
    logic [num_ops-1:0]   odd_period;

    ws_t                  ws_eff;
    phase_t               inc_eff;
    phase_t               mod_shift;
    phase_t               acc_next;
    phase_t               final_next;

    logic                 s1_valid;
    op_idx_t              s1_op;
    ws_t                  s1_ws;
    env_t                 s1_env;

    phase_t               fp;
    logic [7:0]           theta;
    logic [7:0]           saw_idx;
    logic [11:0]          saw;
    logic [11:0]          log_sin;
    logic [GAIN_WIDTH-1:0] gain;
    logic [9:0]           exp_out;
    logic [OP_OUT_WIDTH-1:0] mant;
    logic [OP_OUT_WIDTH-1:0] mag;
    op_out_t              wave;
    op_out_t              wave_abs;
    op_out_t              wave_odd;
    op_out_t              shaped;

    // OPL2 mode only reaches the first four waveforms.
    assign ws_eff = slot.ws & (is_new ? 3'h7 : 3'h3);
    // Alternating and camel sine run at twice the frequency.
    assign inc_eff = (ws_eff == 3'd4 || ws_eff == 3'd5) ? slot.phase_inc << 1 : slot.phase_inc;
    assign mod_shift = phase_t'(PHASE_ACC_WIDTH'(modulation) << 10);
    assign acc_next = phase_acc[slot.op_num] + inc_eff;
    // Modulation shifts the final phase only, never the accumulator.
    assign final_next = acc_next + mod_shift;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ops; i++) begin
                phase_acc[i] <= '0;
                final_phase[i] <= '0;
            end
            odd_period <= '0;
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= slot.slot_valid;
            if (slot.slot_valid) begin
                if (slot.key_on_pulse) begin
                    phase_acc[slot.op_num] <= '0;
                    final_phase[slot.op_num] <= '0;
                    odd_period[slot.op_num] <= 1'b0;
                end else begin
                    phase_acc[slot.op_num] <= acc_next;
                    final_phase[slot.op_num] <= final_next;
                    // A rising phase MSB starts the next period.
                    if (!final_phase[slot.op_num][MSB] && final_next[MSB]) begin
                        odd_period[slot.op_num] <= ~odd_period[slot.op_num];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot.slot_valid) begin
            s1_op <= slot.op_num;
            s1_ws <= ws_eff;
            s1_env <= slot.env;
        end
    end

    assign fp = final_phase[s1_op];
    // Second and fourth quadrants read the table backwards.
    assign theta = fp[MSB-1] ? ~fp[MSB-2:MSB-9] : fp[MSB-2:MSB-9];
    // Log-saw ramp, bit 11 mutes the middle two quadrants.
    assign saw_idx = fp[MSB] ? ~fp[MSB-2:MSB-9] : fp[MSB-2:MSB-9];
    assign saw = {fp[MSB] ^ fp[MSB-1], saw_idx, 3'b000};

    fm_waveform_tables tables (
        .clk     (clk),
        .theta   (theta),
        .log_sin (log_sin),
        .exp_in  (~gain[7:0]),
        .exp_out (exp_out)
    );

    // Attenuation adds in the log domain, eight steps per env unit.
    assign gain = GAIN_WIDTH'(s1_ws == 3'd7 ? saw : log_sin) + {1'b0, s1_env, 3'b000};
    assign mant = {2'b00, 1'b1, exp_out, 1'b0};
    // Integer part of the log value is a plain right shift.
    assign mag = mant >> gain[GAIN_WIDTH-1:8];
    // Upper half wave is negative, one's complement like the chip.
    assign wave = fp[MSB] ? ~mag : mag;
    assign wave_abs = wave[OP_OUT_WIDTH-1] ? ~wave : wave;
    assign wave_odd = odd_period[s1_op] ? wave : '0;

    always_comb begin
        case (s1_ws)
            3'd0: shaped = wave;
            3'd1: shaped = wave[OP_OUT_WIDTH-1] ? '0 : wave;
            3'd2: shaped = wave_abs;
            3'd3: shaped = fp[MSB-1] ? '0 : wave_abs;
            3'd4: shaped = wave_odd;
            3'd5: shaped = wave_odd[OP_OUT_WIDTH-1] ? ~wave_odd : wave_odd;
            3'd6: shaped = (wave > 0) ? OUT_MAX : OUT_MIN;
            default: shaped = wave;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_op <= s1_op;
        out <= shaped;
    end

endmodule

`default_nettype wire

// File: verilog/fm_waveform_tables.sv
/*
 * Log-sine and exponential lookup ROMs for the phase generator.
 * Both are filled at elaboration and read combinationally.
 */
`timescale 1ns/10ps
`default_nettype none

module fm_waveform_tables (
    input  wire logic        clk,
    input  wire logic [7:0]  theta,
    output logic      [11:0] log_sin,
    input  wire logic [7:0]  exp_in,
    output logic      [9:0]  exp_out
);

    localparam int ROM_DEPTH = 256;
    localparam real PI = 3.14159265358979;

    // Quarter wave of -log2(sin), scaled by 256.
    logic [11:0] log_sin_rom [ROM_DEPTH];
    // Fraction of 2^x above one, scaled by 1024.
    logic [9:0]  exp_rom [ROM_DEPTH];

    initial begin
        real angle;
        real frac;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            // Sample at the middle of each step so the first entry stays finite.
            angle = (i + 0.5) * PI / (2.0 * ROM_DEPTH);
            log_sin_rom[i] = 12'($rtoi(-$ln($sin(angle)) / $ln(2.0) * 256.0 + 0.5));
            frac = i / real'(ROM_DEPTH);
            exp_rom[i] = 10'($rtoi(($pow(2.0, frac) - 1.0) * 1024.0 + 0.5));
        end
    end

    assign log_sin = log_sin_rom[theta];
    assign exp_out = exp_rom[exp_in];

endmodule

`default_nettype wire

// File: verilog/operator_sequencer.sv
/*
 * Host register file for the operators and the frame sequencer.
 * A sample_en pulse while idle starts a frame that issues one slot every
 * SLOT_CYCLES clocks, then drains the phase generator pipeline.
 */
`timescale 1ns/10ps
`default_nettype none

module operator_sequencer import fm_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    sample_en,
    input  wire logic    reg_we,
    input  wire op_idx_t reg_op,
    input  wire phase_t  reg_phase_inc,
    input  wire ws_t     reg_ws,
    input  wire env_t    reg_env,
    input  wire logic    reg_key_on,
    slot_if.producer     slot
);

    // Cycles the phase generator needs after the last issue.
    localparam int DRAIN_CYCLES = 2;
    localparam int CNT_WIDTH = $clog2(SLOT_CYCLES);

    phase_t              phase_inc_r [NUM_OPS];
    ws_t                 ws_r [NUM_OPS];
    env_t                env_r [NUM_OPS];
    logic [NUM_OPS-1:0]  key_on_r;
    // Key-on level seen at each operator's last slot.
    logic [NUM_OPS-1:0]  key_on_prev;

    seq_state_t          state;
    op_idx_t             op_cnt;
    logic [CNT_WIDTH-1:0] cnt;

    // Host writes one complete record at a time.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                phase_inc_r[i] <= '0;
                ws_r[i] <= '0;
                env_r[i] <= '1;
            end
            key_on_r <= '0;
        end else if (reg_we) begin
            phase_inc_r[reg_op] <= reg_phase_inc;
            ws_r[reg_op] <= reg_ws;
            env_r[reg_op] <= reg_env;
            key_on_r[reg_op] <= reg_key_on;
        end
    end

    // Frame FSM, sample_en only counts when idle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            op_cnt <= '0;
            cnt <= '0;
            key_on_prev <= '0;
        end else begin
            case (state)
                idle: begin
                    if (sample_en) begin
                        state <= issue;
                        op_cnt <= '0;
                    end
                end
                issue: begin
                    key_on_prev[op_cnt] <= key_on_r[op_cnt];
                    cnt <= '0;
                    if (op_cnt == op_idx_t'(NUM_OPS - 1)) begin
                        state <= drain;
                    end else begin
                        state <= wait_slot;
                    end
                end
                wait_slot: begin
                    // Issue again SLOT_CYCLES after the previous issue.
                    if (cnt == CNT_WIDTH'(SLOT_CYCLES - 2)) begin
                        state <= issue;
                        op_cnt <= op_cnt + 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                drain: begin
                    if (cnt == CNT_WIDTH'(DRAIN_CYCLES - 1)) begin
                        state <= idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Slot fields come straight from the record of the current operator.
    assign slot.slot_valid = (state == issue);
    assign slot.op_num = op_cnt;
    assign slot.phase_inc = phase_inc_r[op_cnt];
    assign slot.ws = ws_r[op_cnt];
    assign slot.env = env_r[op_cnt];
    assign slot.key_on_pulse = slot.slot_valid & key_on_r[op_cnt] & ~key_on_prev[op_cnt];

endmodule

`default_nettype wire

// File: verilog/slot_if.sv
/*
 * One issued operator slot, passed from the sequencer to the phase generator.
 * All fields are valid in the single cycle where slot_valid is high.
 */
`timescale 1ns/10ps
`default_nettype none

interface slot_if import fm_pkg::*; ();

    logic    slot_valid;
    op_idx_t op_num;
    phase_t  phase_inc;
    ws_t     ws;
    env_t    env;
    // High on the first slot after a key-on rising edge.
    logic    key_on_pulse;

    modport producer (
        output slot_valid, op_num, phase_inc, ws, env, key_on_pulse
    );

    modport consumer (
        input slot_valid, op_num, phase_inc, ws, env, key_on_pulse
    );

endinterface

`default_nettype wire

// File: verilog/fm_pkg.sv
/*
 * Shared widths, types and the sequencer state encoding for the FM operator core.
 * Modules take these in with a wildcard import in their header.
 */
`default_nettype none

package fm_pkg;

    // Operators per bank, as two fixed two-operator channels.
    localparam int NUM_OPS = 4;
    // Clocks between two slot issues.
    localparam int SLOT_CYCLES = 4;

    localparam int PHASE_ACC_WIDTH = 20;
    localparam int WS_WIDTH = 3;
    localparam int ENV_WIDTH = 9;
    localparam int OP_OUT_WIDTH = 14;
    localparam int SAMPLE_WIDTH = 16;
    localparam int OP_IDX_WIDTH = 2;

    // Unsigned phase accumulator value.
    typedef logic [PHASE_ACC_WIDTH-1:0] phase_t;
    // Waveform select.
    typedef logic [WS_WIDTH-1:0] ws_t;
    // Attenuation, all ones is the quietest setting.
    typedef logic [ENV_WIDTH-1:0] env_t;
    typedef logic signed [OP_OUT_WIDTH-1:0] op_out_t;
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [OP_IDX_WIDTH-1:0] op_idx_t;

    // Frame sequencer states.
    typedef enum logic [1:0] {
        idle,
        issue,
        wait_slot,
        drain
    } seq_state_t;

endpackage

`default_nettype wire
